// File: sim/decExecTests.txt
# T <name> opens a test; I <pc> <instr> <holds> <event> <a> <b> is one instruction
# event W writes register a with b, R redirects to target a, - expects nothing
T alu_imm
I 00000100 24011234 0 W 01 00001234
I 00000104 2402fff0 0 W 02 fffffff0
I 00000108 34438001 0 W 03 fffffff1
I 0000010c 3064ff0f 0 W 04 0000ff01
I 00000110 3825ffff 0 W 05 0000edcb
I 00000114 3c06abcd 0 W 06 abcd0000
I 00000118 2847fff1 0 W 07 00000001
I 0000011c 28280005 0 W 08 00000000
T alu_reg
I 00000200 00264821 0 W 09 abcd1234
I 00000204 00225023 0 W 0a 00001244
I 00000208 012a1824 0 W 03 00001204
I 0000020c 00662025 0 W 04 abcd1204
I 00000210 00842826 0 W 05 00000000
I 00000214 0045382a 0 W 07 00000001
I 00000218 00a2402a 0 W 08 00000000
I 0000021c 00014a00 0 W 09 00123400
I 00000220 00025102 0 W 0a 0fffffff
I 00000224 00025fc2 0 W 0b 00000001
T zero_reg
I 00000300 24000055 0 - 0 0
I 00000304 240c0007 0 W 0c 00000007
I 00000308 000c6825 0 W 0d 00000007
I 0000030c ffffffff 0 - 0 0
I 00000310 00000000 0 - 0 0
T branches
I 00000400 118d0003 0 R 00000410 0
I 00000404 240e0001 0 - 0 0
I 00000410 240f0002 0 W 0f 00000002
I 00000414 158d0005 0 - 0 0
I 00000418 24100003 0 W 10 00000003
I 0000041c 15f0fffc 0 R 00000410 0
I 00000420 240e0009 0 - 0 0
I 00000410 10010001 0 - 0 0
I 00000414 01c08821 0 W 11 00000000
I 00000418 01f07021 0 W 0e 00000005
T hold
I 00000500 24120010 2 W 12 00000010
I 00000504 26520001 3 W 12 00000011
I 00000508 02529821 1 W 13 00000022
I 0000050c 12730002 2 R 00000518 0
I 00000510 24127777 3 - 0 0
I 00000518 0272a023 0 W 14 00000011

// File: sim.f
common/isaPkg.sv
common/pipePkg.sv
hw/instrDecoder.sv
hw/regFile.sv
hw/decodeExecuteReg.sv
execute/aluUnit.sv
execute/executeStage.sv
hw/decExecCore.sv
sim/clockGen.sv
sim/tbDecExec.sv

// File: Bender.yml
package:
  name: dec_exec_core

sources:
  - files:
      - common/isaPkg.sv
      - common/pipePkg.sv
      - hw/instrDecoder.sv
      - hw/regFile.sv
      - hw/decodeExecuteReg.sv
      - execute/aluUnit.sv
      - execute/executeStage.sv
      - hw/decExecCore.sv
  - target: test
    files:
      - sim/clockGen.sv
      - sim/tbDecExec.sv

// File: sim/tbDecExec.sv
`timescale 1ns/1ps

module tbDecExec;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] word;
        logic [7:0]  holds;    // hold cycles before the instruction may issue
    } instrEntryT;

    typedef struct packed {
        logic           isRedirect;
        isaPkg::regIdxT dest;
        logic [31:0]    value;    // writeback data or redirect target
    } eventT;

    logic           clk;
    logic           arstN;
    logic           instrValid;
    logic [31:0]    instr;
    logic [31:0]    pc;
    logic           hold;
    logic           instrReady;
    logic           wbValid;
    isaPkg::regIdxT wbReg;
    logic [31:0]    wbData;
    logic           redirectValid;
    logic [31:0]    redirectTarget;

    instrEntryT  instrQ[$];
    eventT       expQ[$];
    string       expName[$];
    int          acceptedCount = 0;
    int          cycleCount = 0;
    int          cycleLimit = 0;
    int unsigned seedVal;

    clockGen #(.PeriodNs(4)) clk0 (.clk(clk));

    decExecCore #(.DataWidth(32)) dut0 (
        .clk            (clk),
        .arstN          (arstN),
        .instrValid     (instrValid),
        .instr          (instr),
        .pc             (pc),
        .hold           (hold),
        .instrReady     (instrReady),
        .wbValid        (wbValid),
        .wbReg          (wbReg),
        .wbData         (wbData),
        .redirectValid  (redirectValid),
        .redirectTarget (redirectTarget)
    );

    // ====================
    // checking
    // ====================
    task automatic stopWithFailure(input string why);
        $display("%s", why);
        $display("Some tests failed");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic checkWb(input string testName, input isaPkg::regIdxT expReg,
                           input logic [31:0] expData, input isaPkg::regIdxT gotReg,
                           input logic [31:0] gotData);
        if (expReg !== gotReg || expData !== gotData) begin
            stopWithFailure($sformatf("MISMATCH %s: expected r%0d = %h, got r%0d = %h",
                                      testName, expReg, expData, gotReg, gotData));
        end
    endtask

    task automatic checkRedirect(input string testName, input logic [31:0] expTarget,
                                 input logic [31:0] gotTarget);
        if (expTarget !== gotTarget) begin
            stopWithFailure($sformatf("MISMATCH %s: expected redirect to %h, got %h",
                                      testName, expTarget, gotTarget));
        end
    endtask

    task automatic consumeEvent(input bit isRedirect);
        eventT want;
        string name;
        if (expQ.size() == 0) begin
            stopWithFailure("an event appeared after the last expected one");
        end else begin
            want = expQ.pop_front();
            name = expName.pop_front();
            if (want.isRedirect != isRedirect) begin
                stopWithFailure($sformatf("test %s saw events in the wrong order", name));
            end else if (isRedirect) begin
                checkRedirect(name, want.value, redirectTarget);
            end else begin
                checkWb(name, want.dest, want.value, wbReg, wbData);
            end
        end
    endtask

    // ====================
    // test file
    // ====================
    task automatic loadTests(output int holdTotal);
        int          fd;
        int          n;
        int          holds;
        string       line;
        string       tag;
        string       kind;
        string       testName;
        logic [31:0] pcVal;
        logic [31:0] word;
        logic [31:0] argA;
        logic [31:0] argB;
        instrEntryT  ent;
        eventT       ev;
        holdTotal = 0;
        testName  = "unnamed";
        fd = $fopen("sim/decExecTests.txt", "r");
        if (fd == 0) begin
            stopWithFailure("could not open the test file sim/decExecTests.txt");
        end
        while ($fgets(line, fd) > 0) begin
            n = $sscanf(line, "%s", tag);
            if (n == 1 && tag == "T") begin
                n = $sscanf(line, "%s %s", tag, testName);
            end else if (n == 1 && tag == "I") begin
                n = $sscanf(line, "%s %h %h %d %s %h %h",
                            tag, pcVal, word, holds, kind, argA, argB);
                if (n != 7 || (kind != "W" && kind != "R" && kind != "-")) begin
                    stopWithFailure($sformatf("bad instruction line in test %s", testName));
                end
                ent.pc    = pcVal;
                ent.word  = word;
                ent.holds = holds[7:0];
                instrQ.push_back(ent);
                holdTotal += holds;
                if (kind != "-") begin
                    ev.isRedirect = (kind == "R");
                    ev.dest       = (kind == "R") ? '0 : argA[4:0];
                    ev.value      = (kind == "R") ? argA : argB;
                    expQ.push_back(ev);
                    expName.push_back(testName);
                end
            end
        end
        $fclose(fd);
    endtask

    // ====================
    // stimulus
    // ====================
    task automatic issueInstr(input instrEntryT ent);
        int unsigned extra;
        bit          accepted;
        extra = (($urandom % 4) == 0) ? 1 + ($urandom % 2) : 0;    // random stall pulse
        repeat (ent.holds + extra) begin
            hold       <= 1'b1;
            instrValid <= 1'b1;
            instr      <= ent.word;
            pc         <= ent.pc;
            @(posedge clk);
        end
        hold       <= 1'b0;
        instrValid <= 1'b1;
        instr      <= ent.word;
        pc         <= ent.pc;
        accepted   = 1'b0;
        while (!accepted) begin
            @(negedge clk);
            accepted = instrReady;
            @(posedge clk);
        end
        acceptedCount++;
    endtask

    always @(negedge clk) begin
        if (!arstN) begin
            if (wbValid || redirectValid) begin
                stopWithFailure("a writeback or redirect appeared during reset");
            end
        end else begin
            if (instrReady !== !hold) begin
                stopWithFailure("instrReady was not the inverse of hold");
            end
            if (hold && (wbValid || redirectValid)) begin
                stopWithFailure("a writeback or redirect appeared while hold was high");
            end
            if ((wbValid || redirectValid) && acceptedCount == 0) begin
                stopWithFailure("an event appeared before the first accepted instruction");
            end
            if (wbValid) begin
                consumeEvent(1'b0);    // the writeback belongs to the older instruction
            end
            if (redirectValid) begin
                consumeEvent(1'b1);
            end
        end
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleLimit > 0 && cycleCount >= cycleLimit) begin
            stopWithFailure($sformatf("timeout after %0d cycles", cycleCount));
        end
    end

    initial begin
        int holdTotal;
        int waited;
        arstN      = 1'b0;
        instrValid = 1'b0;
        instr      = '0;
        pc         = '0;
        hold       = 1'b0;
        seedVal    = $urandom(32'h6f3b_7bf1);
        loadTests(holdTotal);
        cycleLimit = 4 * (instrQ.size() + holdTotal) + 50;
        repeat (4) @(posedge clk);
        arstN <= 1'b1;
        foreach (instrQ[i]) begin
            issueInstr(instrQ[i]);
        end
        instrValid <= 1'b0;
        waited = 0;
        while (expQ.size() != 0 && waited < 8) begin
            @(posedge clk);
            waited++;
        end
        repeat (3) @(posedge clk);    // two stages deep, so a stray event would show by now
        if (expQ.size() == 0) begin
            $display("All tests passed");
            $finish;
        end else begin
            stopWithFailure($sformatf("%0d expected events never appeared", expQ.size()));
        end
    end

endmodule

// File: sim/clockGen.sv
`timescale 1ns/1ps

module clockGen #(
    parameter int PeriodNs = 4
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #(PeriodNs / 2) clk = ~clk;
        end
    end

endmodule

// File: hw/decExecCore.sv
`timescale 1ns/1ps

module decExecCore #(
    parameter int DataWidth = 32
) (
    input  logic                 clk,
    input  logic                 arstN,
    input  logic                 instrValid,
    input  logic [31:0]          instr,
    input  logic [31:0]          pc,
    input  logic                 hold,
    output logic                 instrReady,
    output logic                 wbValid,
    output isaPkg::regIdxT       wbReg,
    output logic [DataWidth-1:0] wbData,
    output logic                 redirectValid,
    output logic [31:0]          redirectTarget
);

    pipePkg::ctrlT        decCtrl;
    isaPkg::regIdxT       rsIdx;
    isaPkg::regIdxT       rtIdx;
    logic [31:0]          decImm;
    logic [4:0]           decShamt;
    logic [DataWidth-1:0] rsData;
    logic [DataWidth-1:0] rtData;
    logic                 flush;
    pipePkg::deStageT     deIn;
    pipePkg::deStageT     deOut;

    instrDecoder dec0 (
        .instr (instr),
        .ctrl  (decCtrl),
        .rsIdx (rsIdx),
        .rtIdx (rtIdx),
        .imm   (decImm),
        .shamt (decShamt)
    );

    regFile #(.DataWidth(DataWidth)) rf0 (
        .clk    (clk),
        .arstN  (arstN),
        .rsIdx  (rsIdx),
        .rtIdx  (rtIdx),
        .rsData (rsData),
        .rtData (rtData),
        .wrEn   (wbValid),
        .wrIdx  (wbReg),
        .wrData (wbData)
    );

    // ====================
    // decode bundle
    // ====================
    always_comb begin
        deIn            = pipePkg::DeBubble;
        deIn.ctrl       = decCtrl;
        deIn.ctrl.valid = decCtrl.valid && instrValid;    // empty slots enter as bubbles
        deIn.pc         = pc;
        deIn.rsIdx      = rsIdx;
        deIn.rtIdx      = rtIdx;
        deIn.rsVal      = rsData;
        deIn.rtVal      = rtData;
        deIn.imm        = decImm;
        deIn.shamt      = decShamt;
    end

    decodeExecuteReg deReg0 (
        .clk   (clk),
        .arstN (arstN),
        .hold  (hold),
        .flush (flush),
        .dIn   (deIn),
        .eOut  (deOut)
    );

    executeStage #(.DataWidth(DataWidth)) exe0 (
        .clk            (clk),
        .arstN          (arstN),
        .hold           (hold),
        .eIn            (deOut),
        .flush          (flush),
        .instrReady     (instrReady),
        .wbValid        (wbValid),
        .wbReg          (wbReg),
        .wbData         (wbData),
        .redirectValid  (redirectValid),
        .redirectTarget (redirectTarget)
    );

endmodule

// File: execute/executeStage.sv
`timescale 1ns/1ps

module executeStage #(
    parameter int DataWidth = 32
) (
    input  logic                 clk,
    input  logic                 arstN,
    input  logic                 hold,
    input  pipePkg::deStageT     eIn,
    output logic                 flush,
    output logic                 instrReady,
    output logic                 wbValid,
    output isaPkg::regIdxT       wbReg,
    output logic [DataWidth-1:0] wbData,
    output logic                 redirectValid,
    output logic [31:0]          redirectTarget
);

    pipePkg::ewStageT     ewReg;
    pipePkg::ewStageT     ewNext;
    logic [DataWidth-1:0] opA;
    logic [DataWidth-1:0] rtFwd;
    logic [DataWidth-1:0] opB;
    logic [DataWidth-1:0] aluY;
    logic                 ewWrites;
    logic                 fwdA;
    logic                 fwdB;
    logic                 taken;

    // ====================
    // forwarding
    // ====================
    assign ewWrites = ewReg.valid && ewReg.regWrite && (ewReg.dest != '0);
    assign fwdA     = ewWrites && (ewReg.dest == eIn.rsIdx);
    assign fwdB     = ewWrites && (ewReg.dest == eIn.rtIdx);

    assign opA   = fwdA ? ewReg.result : eIn.rsVal;
    assign rtFwd = fwdB ? ewReg.result : eIn.rtVal;
    assign opB   = eIn.ctrl.useImm ? eIn.imm : rtFwd;

    aluUnit #(.DataWidth(DataWidth)) alu0 (
        .op    (eIn.ctrl.aluOp),
        .a     (opA),
        .b     (opB),
        .shamt (eIn.shamt),
        .y     (aluY)
    );

    // ====================
    // branch resolution
    // ====================
    assign taken = eIn.ctrl.valid && eIn.ctrl.isBranch
                   && ((aluY == '0) != eIn.ctrl.branchOnNe);    // aluY is rs minus rt here

    assign flush          = taken && !hold;    // the redirect is taken at the edge it commits
    assign redirectValid  = flush;
    assign redirectTarget = eIn.pc + 32'd4 + {eIn.imm[29:0], 2'b00};
    assign instrReady     = !hold;

    always_comb begin
        ewNext.valid    = eIn.ctrl.valid;
        ewNext.regWrite = eIn.ctrl.valid && eIn.ctrl.regWrite;
        ewNext.dest     = eIn.ctrl.wbIdx;
        ewNext.result   = aluY;
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            ewReg <= pipePkg::EwBubble;
        end else if (!hold) begin
            ewReg <= ewNext;
        end
    end

    // these also drive the register file write port
    assign wbValid = ewReg.valid && ewReg.regWrite && !hold;
    assign wbReg   = ewReg.dest;
    assign wbData  = ewReg.result;

endmodule

// File: execute/aluUnit.sv
`timescale 1ns/1ps

module aluUnit #(
    parameter int DataWidth = 32
) (
    input  isaPkg::aluOpE        op,
    input  logic [DataWidth-1:0] a,
    input  logic [DataWidth-1:0] b,
    input  logic [4:0]           shamt,
    output logic [DataWidth-1:0] y
);

    logic signedLess;

    assign signedLess = $signed(a) < $signed(b);

    always_comb begin
        case (op)
            isaPkg::ALU_ADD:    y = a + b;
            isaPkg::ALU_SUB:    y = a - b;
            isaPkg::ALU_AND:    y = a & b;
            isaPkg::ALU_OR:     y = a | b;
            isaPkg::ALU_XOR:    y = a ^ b;
            isaPkg::ALU_SLT:    y = {{(DataWidth-1){1'b0}}, signedLess};
            isaPkg::ALU_SLL:    y = b << shamt;    // shifts act on rt, as in MIPS
            isaPkg::ALU_SRL:    y = b >> shamt;
            isaPkg::ALU_LUI:    y = b << 16;
            isaPkg::ALU_PASS_B: y = b;
            default:            y = b;
        endcase
    end

endmodule

// File: hw/decodeExecuteReg.sv
`timescale 1ns/1ps

module decodeExecuteReg (
    input  logic             clk,
    input  logic             arstN,
    input  logic             hold,
    input  logic             flush,
    input  pipePkg::deStageT dIn,
    output pipePkg::deStageT eOut
);

    // ====================
    // stage register
    // ====================
    // flush wins over hold so a squashed slot never survives a stall
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            eOut <= pipePkg::DeBubble;
        end else if (flush) begin
            eOut <= pipePkg::DeBubble;    // younger instruction behind a taken branch
        end else if (!hold) begin
            eOut <= dIn;
        end
    end

endmodule

// File: hw/regFile.sv
`timescale 1ns/1ps

module regFile #(
    parameter int DataWidth = 32
) (
    input  logic                 clk,
    input  logic                 arstN,
    input  isaPkg::regIdxT       rsIdx,
    input  isaPkg::regIdxT       rtIdx,
    output logic [DataWidth-1:0] rsData,
    output logic [DataWidth-1:0] rtData,
    input  logic                 wrEn,
    input  isaPkg::regIdxT       wrIdx,
    input  logic [DataWidth-1:0] wrData
);

    logic [DataWidth-1:0] regs [1:31];    // register zero has no storage
    logic                 wrLive;

    assign wrLive = wrEn && (wrIdx != '0);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wrLive) begin
            regs[wrIdx] <= wrData;
        end
    end

    function automatic logic [DataWidth-1:0] readPort(isaPkg::regIdxT idx);
        if (idx == '0) begin
            return '0;
        end
        if (wrLive && (idx == wrIdx)) begin
            return wrData;    // a write in this cycle is visible to decode
        end
        return regs[idx];
    endfunction

    always_comb begin
        rsData = readPort(rsIdx);
        rtData = readPort(rtIdx);
    end

endmodule

// File: hw/instrDecoder.sv
`timescale 1ns/1ps

module instrDecoder (
    input  logic            [31:0] instr,
    output pipePkg::ctrlT          ctrl,
    output isaPkg::regIdxT         rsIdx,
    output isaPkg::regIdxT         rtIdx,
    output logic            [31:0] imm,
    output logic            [4:0]  shamt
);

    isaPkg::rFormatT rFields;
    isaPkg::iFormatT iFields;
    isaPkg::regIdxT  destIdx;
    logic            signExt;
    logic            known;

    assign rFields = instr;
    assign iFields = instr;

    assign rsIdx = rFields.rs;
    assign rtIdx = rFields.rt;
    assign shamt = rFields.shamt;

    assign imm = signExt ? {{16{iFields.imm[15]}}, iFields.imm} : {16'h0000, iFields.imm};

    always_comb begin
        ctrl       = '0;
        ctrl.aluOp = isaPkg::ALU_PASS_B;
        destIdx    = rFields.rt;
        signExt    = 1'b0;
        known      = 1'b1;
        case (isaPkg::opcodeE'(rFields.opcode))
            isaPkg::OP_SPECIAL: begin
                destIdx       = rFields.rd;
                ctrl.regWrite = 1'b1;
                case (isaPkg::functE'(rFields.funct))
                    isaPkg::FN_ADDU: ctrl.aluOp = isaPkg::ALU_ADD;
                    isaPkg::FN_SUBU: ctrl.aluOp = isaPkg::ALU_SUB;
                    isaPkg::FN_AND:  ctrl.aluOp = isaPkg::ALU_AND;
                    isaPkg::FN_OR:   ctrl.aluOp = isaPkg::ALU_OR;
                    isaPkg::FN_XOR:  ctrl.aluOp = isaPkg::ALU_XOR;
                    isaPkg::FN_SLT:  ctrl.aluOp = isaPkg::ALU_SLT;
                    isaPkg::FN_SLL:  ctrl.aluOp = isaPkg::ALU_SLL;
                    isaPkg::FN_SRL:  ctrl.aluOp = isaPkg::ALU_SRL;
                    default:         known      = 1'b0;
                endcase
            end
            isaPkg::OP_ADDIU, isaPkg::OP_SLTI: begin
                ctrl.aluOp    = (rFields.opcode == isaPkg::OP_SLTI) ? isaPkg::ALU_SLT
                                                                     : isaPkg::ALU_ADD;
                ctrl.useImm   = 1'b1;
                ctrl.regWrite = 1'b1;
                signExt       = 1'b1;
            end
            isaPkg::OP_ANDI, isaPkg::OP_ORI, isaPkg::OP_XORI: begin
                ctrl.useImm   = 1'b1;    // logical immediates are zero-extended
                ctrl.regWrite = 1'b1;
                ctrl.aluOp    = (rFields.opcode == isaPkg::OP_ANDI) ? isaPkg::ALU_AND :
                                (rFields.opcode == isaPkg::OP_ORI)  ? isaPkg::ALU_OR
                                                                     : isaPkg::ALU_XOR;
            end
            isaPkg::OP_LUI: begin
                ctrl.aluOp    = isaPkg::ALU_LUI;
                ctrl.useImm   = 1'b1;
                ctrl.regWrite = 1'b1;
            end
            isaPkg::OP_BEQ, isaPkg::OP_BNE: begin
                ctrl.aluOp      = isaPkg::ALU_SUB;    // equality from a zero difference
                ctrl.isBranch   = 1'b1;
                ctrl.branchOnNe = (rFields.opcode == isaPkg::OP_BNE);
                signExt         = 1'b1;
            end
            default: known = 1'b0;
        endcase
        ctrl.wbIdx    = destIdx;
        ctrl.valid    = known;
        ctrl.regWrite = ctrl.regWrite && known && (destIdx != '0);
    end

endmodule

// File: common/pipePkg.sv
package pipePkg;

    // ====================
    // decoded control word
    // ====================
    typedef struct packed {
        isaPkg::aluOpE  aluOp;
        logic           useImm;        // b operand comes from the immediate
        logic           regWrite;
        logic           isBranch;
        logic           branchOnNe;    // set for BNE, clear for BEQ
        isaPkg::regIdxT wbIdx;         // rd for R-type, rt for I-type
        logic           valid;
    } ctrlT;

    // ====================
    // stage registers
    // ====================
    typedef struct packed {
        ctrlT           ctrl;
        logic [31:0]    pc;
        isaPkg::regIdxT rsIdx;
        isaPkg::regIdxT rtIdx;
        logic [31:0]    rsVal;
        logic [31:0]    rtVal;
        logic [31:0]    imm;           // already extended in decode
        logic [4:0]     shamt;
    } deStageT;

    typedef struct packed {
        logic           valid;
        logic           regWrite;
        isaPkg::regIdxT dest;
        logic [31:0]    result;
    } ewStageT;

    // an all-zero entry has valid low and behaves as a no-op
    localparam deStageT DeBubble = '0;
    localparam ewStageT EwBubble = '0;

endpackage

// File: common/isaPkg.sv
package isaPkg;

    typedef logic [4:0] regIdxT;

    // ====================
    // instruction formats
    // ====================
    typedef struct packed {
        logic [5:0] opcode;
        regIdxT     rs;
        regIdxT     rt;
        regIdxT     rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } rFormatT;

    typedef struct packed {
        logic [5:0]  opcode;
        regIdxT      rs;
        regIdxT      rt;
        logic [15:0] imm;
    } iFormatT;

    // ====================
    // opcodes and function codes
    // ====================
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,    // R-type with the operation picked by funct
        OP_BEQ     = 6'h04,
        OP_BNE     = 6'h05,
        OP_ADDIU   = 6'h09,
        OP_SLTI    = 6'h0a,
        OP_ANDI    = 6'h0c,
        OP_ORI     = 6'h0d,
        OP_XORI    = 6'h0e,
        OP_LUI     = 6'h0f
    } opcodeE;

    typedef enum logic [5:0] {
        FN_SLL  = 6'h00,
        FN_SRL  = 6'h02,
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_XOR  = 6'h26,
        FN_SLT  = 6'h2a
    } functE;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLL,
        ALU_SRL,
        ALU_LUI,
        ALU_PASS_B    // result is operand b unchanged
    } aluOpE;

endpackage
